// ==== Makefile ====
# Verilator flow for the pulse timing subsystem
# override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TB_TOP    ?= pulse_timing_tb
RTL_TOP   ?= pulse_timing_top
FILELIST  ?= pulse_timing_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=

.PHONY: all lint sim clean

all: sim

# lint the design from the RTL top level
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# build and run; a $$fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// ==== include/pulse_consts.svh ====
`ifndef PULSE_CONSTS_SVH
`define PULSE_CONSTS_SVH

// host register map
`define REG_PERIOD   4'd0
`define REG_SYNC_UP  4'd1
`define REG_P1WIDTH  4'd2
`define REG_P2START  4'd3
`define REG_ATT_DOWN 4'd4
`define REG_DELAY    4'd5
`define REG_OFFRES   4'd6
`define REG_ATTEN    4'd7
// data ignored, sends the staged set
`define REG_COMMIT   4'd8

// field lsbs inside the REG_ATTEN word
`define ATTEN_PP_PUMP_LSB  0
`define ATTEN_PP_PROBE_LSB 7
`define ATTEN_POST_ATT_LSB 14
`define ATTEN_DOUBLE_LSB   21
`define ATTEN_PUMP_ON_LSB  22

// buffer entries, also the loader's credits after reset
`define FIFO_DEPTH 4
// att3 drops this many counts before sync_up
`define ATT3_LEAD  30

`endif

// ==== pulse_timing_top.f ====
+incdir+include
source/pulse_pkg.sv
source/timing_loader.sv
source/timing_fifo.sv
source/pulse_sequencer.sv
source/pulse_timing_top.sv
test/pulse_timing_tb.sv

// ==== source/pulse_pkg.sv ====
package pulse_pkg;

   // one complete timing set as loaded by the host
   // all times are in clk_pll counts from the start of the frame
   typedef struct packed {
      // last counter value of the frame, the frame is period+1 counts long
      logic [31:0] period;
      // end of the sync gate
      logic [31:0] sync_up;
      // pump pulse width
      logic [31:0] p1width;
      // start of the probe pulse
      logic [31:0] p2start;
      // end of the probe attenuation and of the record window
      logic [31:0] att_down;
      // record window offset after sync_up
      logic [31:0] delay;
      // start of the off-resonance second pulse
      logic [31:0] offres_delay;
      // attenuator codes
      logic [6:0]  pp_pump;
      logic [6:0]  pp_probe;
      logic [6:0]  post_att;
      // second pulse enable and its inverted polarity
      logic        double_pulse;
      logic        pump_on;
   } pulse_timing_t;

   // single register write from the host
   typedef struct packed {
      logic [3:0]  addr;
      logic [31:0] data;
   } host_wr_t;

   // registered sequencer outputs
   typedef struct packed {
      logic        sync_on;
      logic        pulse_on;
      logic [6:0]  att1;
      logic [6:0]  att3;
      logic        record_start;
      // marks the cycle that carries counter 0
      logic        frame_start;
   } pulse_out_t;

endpackage

// ==== source/pulse_sequencer.sv ====
`timescale 1ns/1ps
`include "pulse_consts.svh"

module pulse_sequencer
   import pulse_pkg::*;
(
   input  logic          clk_pll,
   input  logic          resetn,
   input  logic          avail,
   input  pulse_timing_t head,
   output logic          pop,
   input  logic          pump,
   output pulse_out_t    pulse
);

   pulse_timing_t cur;
   logic          armed;
   logic [31:0]   counter;
   logic          frame_end;
   logic [31:0]   att1_end;
   logic [31:0]   att3_end;
   logic [31:0]   offres_end;
   logic [31:0]   rec_begin;
   logic          offres_win;
   pulse_out_t    pulse_nxt;

   // last count of the current frame
   assign frame_end = armed && (counter == cur.period);
   // take a set when idle, or at the frame boundary if one is waiting
   assign pop       = avail && (!armed || frame_end);

   // thresholds, 32-bit wrap as in the bench hardware
   assign att1_end   = cur.p1width + 32'd1;
   assign att3_end   = cur.sync_up - 32'(`ATT3_LEAD);
   assign offres_end = cur.offres_delay + cur.p1width;
   assign rec_begin  = cur.sync_up + cur.delay;

   // off-resonance second pulse window, open interval
   assign offres_win = cur.double_pulse &&
                       (counter > cur.offres_delay) &&
                       (counter < offres_end);

   // output decode for the present counter value
   always_comb begin
      pulse_nxt = '0;
      if (armed) begin
         pulse_nxt.sync_on = (counter < cur.sync_up);
         // pump pulse, gap, probe up to sync_up, then optional second pulse
         if (counter < cur.p1width) begin
            pulse_nxt.pulse_on = pump;
         end else if (counter < cur.p2start) begin
            pulse_nxt.pulse_on = 1'b0;
         end else if (counter < cur.sync_up) begin
            pulse_nxt.pulse_on = 1'b1;
         end else begin
            pulse_nxt.pulse_on = offres_win && !cur.pump_on;
         end
         // pump code around the pump pulse and after att_down
         if ((counter < att1_end) || (counter > cur.att_down)) begin
            pulse_nxt.att1 = cur.pp_pump;
         end else begin
            pulse_nxt.att1 = cur.pp_probe;
         end
         // att3 opens ahead of the end of sync
         if ((counter < att3_end) || (counter > cur.att_down)) begin
            pulse_nxt.att3 = cur.post_att;
         end else begin
            pulse_nxt.att3 = '0;
         end
         pulse_nxt.record_start = (counter >= rec_begin) && (counter < cur.att_down);
         pulse_nxt.frame_start  = (counter == 32'd0);
      end
   end

   // counter, armed flag and registered outputs
   always_ff @(posedge clk_pll) begin
      if (resetn) begin
         armed   <= 1'b0;
         counter <= '0;
         pulse   <= '0;
      end else begin
         pulse <= pulse_nxt;
         if (pop) begin
            armed <= 1'b1;
         end
         // held at 0 while idle so the first set starts clean
         if (!armed || frame_end) begin
            counter <= '0;
         end else begin
            counter <= counter + 32'd1;
         end
      end
   end

   // active set, replaced only on a pop
   always_ff @(posedge clk_pll) begin
      if (pop) begin
         cur <= head;
      end
   end

   // no frame marker before a set has been taken
   a_frame_armed: assert property (
      @(posedge clk_pll) disable iff (resetn)
      pulse.frame_start |-> $past(armed)
   ) else $error("frame_start while idle");

endmodule

// ==== source/pulse_timing_top.sv ====
`timescale 1ns/1ps
`include "pulse_consts.svh"

module pulse_timing_top
   import pulse_pkg::*;
(
   input  logic       clk_pll,
   input  logic       resetn,
   input  logic       host_valid,
   input  host_wr_t   host_wr,
   output logic       host_ready,
   input  logic       pump,
   output pulse_out_t pulse
);

   // loader to buffer
   logic          push;
   pulse_timing_t push_data;
   logic          credit_return;

   // buffer to sequencer
   logic          avail;
   pulse_timing_t head;
   logic          pop;

   // host writes staged into timing sets
   timing_loader i_loader (
      .clk_pll       (clk_pll),
      .resetn        (resetn),
      .host_valid    (host_valid),
      .host_wr       (host_wr),
      .host_ready    (host_ready),
      .push          (push),
      .push_data     (push_data),
      .credit_return (credit_return)
   );

   // committed sets waiting for a frame boundary
   timing_fifo #(
      .DEPTH     (`FIFO_DEPTH),
      .payload_t (pulse_timing_t)
   ) i_fifo (
      .clk_pll       (clk_pll),
      .resetn        (resetn),
      .push          (push),
      .push_data     (push_data),
      .avail         (avail),
      .head          (head),
      .pop           (pop),
      .credit_return (credit_return)
   );

   // frame counter and pulse outputs
   pulse_sequencer i_seq (
      .clk_pll (clk_pll),
      .resetn  (resetn),
      .avail   (avail),
      .head    (head),
      .pop     (pop),
      .pump    (pump),
      .pulse   (pulse)
   );

endmodule

// ==== source/timing_fifo.sv ====
`timescale 1ns/1ps
`include "pulse_consts.svh"

module timing_fifo #(
   parameter int  DEPTH     = `FIFO_DEPTH,
   parameter type payload_t = logic
) (
   input  logic     clk_pll,
   input  logic     resetn,
   input  logic     push,
   input  payload_t push_data,
   output logic     avail,
   output payload_t head,
   input  logic     pop,
   output logic     credit_return
);

   // pointer width, at least one bit for a single entry
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;

   // wrap at DEPTH so any depth works
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign avail = (count != '0);
   assign full  = (count == CNT_W'(DEPTH));
   // show-ahead read
   assign head  = mem[rd_ptr];

   // storage
   always_ff @(posedge clk_pll) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // pointers, occupancy and the credit pulse
   always_ff @(posedge clk_pll) begin
      if (resetn) begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         count         <= '0;
         credit_return <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         count         <= count + CNT_W'(push) - CNT_W'(pop);
         // one credit back per freed slot
         credit_return <= pop;
      end
   end

   // loader credits must keep us from overflowing
   a_no_push_full: assert property (
      @(posedge clk_pll) disable iff (resetn)
      push |-> !full
   ) else $error("push into a full buffer");

   a_no_pop_empty: assert property (
      @(posedge clk_pll) disable iff (resetn)
      pop |-> avail
   ) else $error("pop from an empty buffer");

endmodule

// ==== source/timing_loader.sv ====
`timescale 1ns/1ps
`include "pulse_consts.svh"

module timing_loader
   import pulse_pkg::*;
(
   input  logic          clk_pll,
   input  logic          resetn,
   input  logic          host_valid,
   input  host_wr_t      host_wr,
   output logic          host_ready,
   output logic          push,
   output pulse_timing_t push_data,
   input  logic          credit_return
);

   // wide enough to hold the full credit count
   localparam int CRED_W = $clog2(`FIFO_DEPTH + 1);

   logic              wr_acc;
   logic              commit_acc;
   logic [CRED_W-1:0] credits;
   pulse_timing_t     shadow;

   // one free buffer slot is needed before any write is taken
   assign host_ready = (credits != '0);
   assign wr_acc     = host_valid && host_ready;
   assign commit_acc = wr_acc && (host_wr.addr == `REG_COMMIT);

   // staged set, one register per write
   always_ff @(posedge clk_pll) begin
      if (resetn) begin
         shadow <= '0;
      end else if (wr_acc) begin
         case (host_wr.addr)
            `REG_PERIOD:   shadow.period       <= host_wr.data;
            `REG_SYNC_UP:  shadow.sync_up      <= host_wr.data;
            `REG_P1WIDTH:  shadow.p1width      <= host_wr.data;
            `REG_P2START:  shadow.p2start      <= host_wr.data;
            `REG_ATT_DOWN: shadow.att_down     <= host_wr.data;
            `REG_DELAY:    shadow.delay        <= host_wr.data;
            `REG_OFFRES:   shadow.offres_delay <= host_wr.data;
            `REG_ATTEN: begin
               // packed attenuator word
               shadow.pp_pump      <=
                  host_wr.data[`ATTEN_PP_PUMP_LSB +: $bits(shadow.pp_pump)];
               shadow.pp_probe     <=
                  host_wr.data[`ATTEN_PP_PROBE_LSB +: $bits(shadow.pp_probe)];
               shadow.post_att     <=
                  host_wr.data[`ATTEN_POST_ATT_LSB +: $bits(shadow.post_att)];
               shadow.double_pulse <= host_wr.data[`ATTEN_DOUBLE_LSB];
               shadow.pump_on      <= host_wr.data[`ATTEN_PUMP_ON_LSB];
            end
            // commit and unmapped addresses leave the shadow alone
            default: ;
         endcase
      end
   end

   // push follows the commit write by one cycle
   always_ff @(posedge clk_pll) begin
      if (resetn) begin
         push <= 1'b0;
      end else begin
         push <= commit_acc;
      end
   end

   // snapshot of the shadow as it stood at the commit
   always_ff @(posedge clk_pll) begin
      if (commit_acc) begin
         push_data <= shadow;
      end
   end

   // credit is taken at the commit, so the push in flight already owns one
   // returns come back one per popped entry
   always_ff @(posedge clk_pll) begin
      if (resetn) begin
         credits <= CRED_W'(`FIFO_DEPTH);
      end else begin
         credits <= credits - CRED_W'(commit_acc) + CRED_W'(credit_return);
      end
   end

   // every push was paid for on the cycle before
   a_push_has_credit: assert property (
      @(posedge clk_pll) disable iff (resetn)
      push |-> ($past(credits) != '0)
   ) else $error("push without a held credit");

   // the buffer never returns more credits than it has entries
   a_credit_bound: assert property (
      @(posedge clk_pll) disable iff (resetn)
      credits <= CRED_W'(`FIFO_DEPTH)
   ) else $error("credit count above buffer depth");

endmodule

// ==== test/pulse_timing_tb.sv ====
`timescale 1ns/1ps
`include "pulse_consts.svh"

module pulse_timing_tb
   import pulse_pkg::*;
();

   // upper bound for any single wait in clock cycles
   localparam int WAIT_LIMIT = 4000;
   // where a checked frame starts relative to the current sample
   localparam int START_HERE = 0;
   localparam int START_NEXT = 1;
   localparam int START_WAIT = 2;

   logic       clk_pll;
   logic       resetn;
   logic       host_valid;
   host_wr_t   host_wr;
   logic       host_ready;
   logic       pump;
   pulse_out_t pulse;

   // random source state
   logic [31:0] lfsr = 32'h2f5c_2a8a;

   pulse_timing_top i_dut (
      .clk_pll    (clk_pll),
      .resetn     (resetn),
      .host_valid (host_valid),
      .host_wr    (host_wr),
      .host_ready (host_ready),
      .pump       (pump),
      .pulse      (pulse)
   );

   // 40 ns period
   always #20 clk_pll = ~clk_pll;

   task automatic fail_stop(input string reason);
      $display("%s", reason);
      $display("*** FAILED ***");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         fail_stop($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   // fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      logic        fb;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   // ordered times p1width < p2start < sync_up < att_down < period
   // pump width of two or more keeps the second pulse window open
   // worst case att_down is 143 and the second pulse ends by 127
   task automatic make_set(input logic dbl, input logic [31:0] base, output pulse_timing_t s);
      logic [31:0] r;
      s = '0;
      r = random_bits(4);
      s.p1width = 32'd2 + r;
      r = random_bits(4);
      s.p2start = s.p1width + 32'd1 + r;
      r = random_bits(4);
      s.sync_up = s.p2start + 32'(`ATT3_LEAD) + 32'd1 + r;
      r = random_bits(6);
      s.att_down = s.sync_up + 32'd1 + r;
      r = random_bits(5);
      s.delay = r;
      r = random_bits(5);
      s.offres_delay = s.sync_up + r;
      r = random_bits(7);
      s.pp_pump = r[6:0];
      r = random_bits(7);
      s.pp_probe = r[6:0];
      r = random_bits(7);
      s.post_att = r[6:0];
      r = random_bits(1);
      s.pump_on = r[0];
      s.double_pulse = dbl;
      // base keeps periods of one test apart
      r = random_bits(6);
      s.period = base + r;
   endtask

   // expected outputs for one counter value of a frame
   function automatic pulse_out_t model_out(input pulse_timing_t s, input logic [31:0] c,
                                            input logic pmp);
      pulse_out_t o;
      logic       second;
      o = '0;
      second = s.double_pulse && (c > s.offres_delay) && (c < s.offres_delay + s.p1width);
      o.sync_on = (c < s.sync_up);
      // pump, gap, probe until sync_up, then the inverted second pulse
      o.pulse_on = (c < s.p1width) ? pmp :
                   (c < s.p2start) ? 1'b0 :
                   (c < s.sync_up) ? 1'b1 : (second && !s.pump_on);
      // probe code from just past the pump pulse through att_down
      o.att1 = ((c > s.p1width) && (c <= s.att_down)) ? s.pp_probe : s.pp_pump;
      // att3 dark from the lead point through att_down
      o.att3 = ((c >= s.sync_up - 32'(`ATT3_LEAD)) && (c <= s.att_down)) ? 7'd0 : s.post_att;
      o.record_start = (c >= s.sync_up + s.delay) && (c < s.att_down);
      o.frame_start = (c == 32'd0);
      return o;
   endfunction

   // entered and left 1 ns after a rising edge
   task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
      int cycles;
      host_wr.addr = addr;
      host_wr.data = data;
      host_valid   = 1'b1;
      cycles       = 0;
      while (!host_ready) begin
         @(posedge clk_pll);
         #1;
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            fail_stop("timeout: host_ready never came back for a register write");
         end
      end
      @(posedge clk_pll);
      #1;
      host_valid = 1'b0;
   endtask

   task automatic commit_set(input pulse_timing_t s);
      logic [31:0] atten;
      atten = '0;
      atten[`ATTEN_PP_PUMP_LSB +: 7]  = s.pp_pump;
      atten[`ATTEN_PP_PROBE_LSB +: 7] = s.pp_probe;
      atten[`ATTEN_POST_ATT_LSB +: 7] = s.post_att;
      atten[`ATTEN_DOUBLE_LSB]        = s.double_pulse;
      atten[`ATTEN_PUMP_ON_LSB]       = s.pump_on;
      write_reg(`REG_PERIOD, s.period);
      write_reg(`REG_SYNC_UP, s.sync_up);
      write_reg(`REG_P1WIDTH, s.p1width);
      write_reg(`REG_P2START, s.p2start);
      write_reg(`REG_ATT_DOWN, s.att_down);
      write_reg(`REG_DELAY, s.delay);
      write_reg(`REG_OFFRES, s.offres_delay);
      write_reg(`REG_ATTEN, atten);
      write_reg(`REG_COMMIT, 32'd0);
   endtask

   // moves at least one cycle and stops on the sample carrying counter 0
   task automatic wait_frame_start();
      int cycles;
      cycles = 0;
      do begin
         @(posedge clk_pll);
         #1;
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            fail_stop("timeout: no frame_start seen");
         end
      end while (!pulse.frame_start);
   endtask

   task automatic match_outputs(input pulse_timing_t s, input logic [31:0] c);
      pulse_out_t e;
      e = model_out(s, c, pump);
      compare("pulse.sync_on", 32'(pulse.sync_on), 32'(e.sync_on));
      compare("pulse.pulse_on", 32'(pulse.pulse_on), 32'(e.pulse_on));
      compare("pulse.att1", 32'(pulse.att1), 32'(e.att1));
      compare("pulse.att3", 32'(pulse.att3), 32'(e.att3));
      compare("pulse.record_start", 32'(pulse.record_start), 32'(e.record_start));
      compare("pulse.frame_start", 32'(pulse.frame_start), 32'(e.frame_start));
   endtask

   // every cycle of one frame up to the sample of counter == period
   task automatic verify_frame(input pulse_timing_t s, input int mode);
      logic [31:0] c;
      if (mode == START_WAIT) begin
         wait_frame_start();
      end else if (mode == START_NEXT) begin
         @(posedge clk_pll);
         #1;
      end
      c = 32'd0;
      match_outputs(s, c);
      while (c < s.period) begin
         c = c + 32'd1;
         @(posedge clk_pll);
         #1;
         match_outputs(s, c);
      end
   endtask

   // nothing committed so the sequencer must stay quiet
   task automatic reset_idle();
      repeat (200) begin
         @(posedge clk_pll);
         #1;
         compare("pulse", 32'(pulse), 32'd0);
         compare("host_ready", 32'(host_ready), 32'd1);
      end
   endtask

   task automatic single_pulse_frames();
      pulse_timing_t s;
      make_set(1'b0, 32'd200, s);
      pump = 1'b1;
      commit_set(s);
      verify_frame(s, START_WAIT);
      // new pump level takes effect from counter 0 of the next frame
      pump = 1'b0;
      verify_frame(s, START_NEXT);
   endtask

   task automatic double_pulse_frames();
      pulse_timing_t s;
      int            k;
      pump = 1'b1;
      for (k = 0; k < 2; k++) begin
         make_set(1'b1, 32'd200, s);
         s.pump_on = k[0];
         // commit early in a frame so the set takes the next boundary
         wait_frame_start();
         commit_set(s);
         verify_frame(s, START_WAIT);
      end
   endtask

   task automatic ordered_handover();
      pulse_timing_t sets [3];
      int            k;
      pump = 1'b1;
      for (k = 0; k < 3; k++) begin
         make_set(k[0], 32'd200 + 32'(k) * 32'd80, sets[k]);
      end
      wait_frame_start();
      for (k = 0; k < 3; k++) begin
         commit_set(sets[k]);
      end
      // back to back frames give spacing of period+1
      verify_frame(sets[0], START_WAIT);
      verify_frame(sets[1], START_NEXT);
      verify_frame(sets[2], START_NEXT);
      // last set repeats once the fifo is empty
      verify_frame(sets[2], START_NEXT);
   endtask

   task automatic credit_backpressure();
      pulse_timing_t hold;
      pulse_timing_t sets [`FIFO_DEPTH];
      int            k;
      int            cycles;
      pump = 1'b0;
      make_set(1'b0, 32'd1000, hold);
      wait_frame_start();
      commit_set(hold);
      // long frame running with an empty fifo
      wait_frame_start();
      compare("host_ready", 32'(host_ready), 32'd1);
      for (k = 0; k < `FIFO_DEPTH; k++) begin
         make_set(k[0], 32'd200 + 32'(k) * 32'd70, sets[k]);
         commit_set(sets[k]);
         compare("host_ready", 32'(host_ready), (k < `FIFO_DEPTH - 1) ? 32'd1 : 32'd0);
      end
      // ready stays low until the first queued set is popped
      cycles = 0;
      do begin
         @(posedge clk_pll);
         #1;
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            fail_stop("timeout: long frame never ended under back-pressure");
         end
         if (!pulse.frame_start) begin
            compare("host_ready", 32'(host_ready), 32'd0);
         end
      end while (!pulse.frame_start);
      compare("host_ready", 32'(host_ready), 32'd1);
      verify_frame(sets[0], START_HERE);
      for (k = 1; k < `FIFO_DEPTH; k++) begin
         verify_frame(sets[k], START_NEXT);
      end
      verify_frame(sets[`FIFO_DEPTH - 1], START_NEXT);
   endtask

   initial begin
      clk_pll    = 1'b0;
      resetn     = 1'b1;
      host_valid = 1'b0;
      host_wr    = '0;
      pump       = 1'b0;
      repeat (3) @(posedge clk_pll);
      #1;
      resetn = 1'b0;
      reset_idle();
      single_pulse_frames();
      double_pulse_frames();
      ordered_handover();
      credit_backpressure();
      $display("*** PASSED ***");
      $finish;
   end

endmodule
